//--- logic/alu_execute.sv
`default_nettype none

module alu_execute (
	input logic clk,
	input logic rst,
	input logic issue,
	input core_pkg::op_t op,
	input logic [core_pkg::REG_W-1:0] rd,
	input logic [core_pkg::REG_W-1:0] rs,
	input logic [core_pkg::REG_W-1:0] rt,
	input logic [core_pkg::IMM_W-1:0] imm,
	output logic mem_wen,
	output core_pkg::slot_t mem_addr,
	output core_pkg::word_t mem_data
);

	core_pkg::word_t regs [core_pkg::REG_COUNT];
	core_pkg::word_t a;
	core_pkg::word_t b;
	core_pkg::word_t imm_ext;
	core_pkg::word_t result;
	logic writes;
	logic is_store;

	assign a = regs[rs];
	assign b = regs[rt];
	assign imm_ext = {{(core_pkg::WORD_W - core_pkg::IMM_W){imm[core_pkg::IMM_W-1]}}, imm};
	assign is_store = issue && (op == core_pkg::OP_STORE);

	always_comb begin
		result = '0;
		writes = 1'b1;
		case (op)
			core_pkg::OP_ADDI: result = a + imm_ext;
			core_pkg::OP_ADD: result = a + b;
			core_pkg::OP_SUB: result = a - b;
			core_pkg::OP_AND: result = a & b;
			core_pkg::OP_OR: result = a | b;
			core_pkg::OP_XOR: result = a ^ b;
			core_pkg::OP_SLT: begin
				result = {{(core_pkg::WORD_W - 1){1'b0}}, $signed(a) < $signed(b)};
			end
			default: writes = 1'b0; // store, halt and unused codes.
		endcase
	end

	// register 0 is never written, so it keeps reading zero.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < core_pkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (issue && writes && rd != '0) begin
			regs[rd] <= result;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			mem_wen <= 1'b0;
		end else begin
			mem_wen <= is_store;
		end
	end

	always_ff @(posedge clk) begin
		if (is_store) begin
			mem_addr <= core_pkg::slot_t'(imm);
			mem_data <= core_pkg::swap_bytes(a); // machine stores little-endian.
		end
	end

endmodule

`default_nettype wire

//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int WORD_W = 32;
	localparam int SLOT_W = 6;
	localparam int REG_W = 3;
	localparam int IMM_W = 6;
	localparam int ERR_W = 8;
	localparam int DUR_W = 16;

	localparam int PROG_DEPTH = 64;
	localparam int CHECK_NUM = 14; // slots at or above are not checked.
	localparam int REG_COUNT = 8;
	localparam logic [ERR_W-1:0] ERR_IDLE = 8'd255;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [SLOT_W-1:0] slot_t;

	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_AND = 4'h2,
		OP_OR = 4'h3,
		OP_XOR = 4'h4,
		OP_SLT = 4'h5,
		OP_ADDI = 4'h6,
		OP_STORE = 4'h7,
		OP_HALT = 4'hf
	} op_t;

	// rt sits in the low bits of imm.
	typedef struct packed {
		logic [3:0] opcode;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] rs;
		logic [IMM_W-1:0] imm;
	} instr_t;

	// little-endian store order to readable order and back.
	function automatic word_t swap_bytes(input word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

endpackage

`default_nettype wire

//--- logic/cpu_check_top.sv
`default_nettype none

module cpu_check_top (
	input logic clk,
	input logic rst,
	input logic start,
	input logic prog_wen,
	input core_pkg::slot_t prog_addr,
	input core_pkg::instr_t prog_data,
	input logic ans_wen,
	input core_pkg::slot_t ans_addr,
	input core_pkg::word_t ans_data,
	output logic mem_wen,
	output core_pkg::slot_t mem_addr,
	output core_pkg::word_t mem_data,
	output logic [core_pkg::ERR_W-1:0] error_num,
	output logic [core_pkg::DUR_W-1:0] duration,
	output logic finish
);

	core_pkg::slot_t fetch_addr;
	core_pkg::instr_t instr;
	logic issue;
	core_pkg::op_t op;
	logic [core_pkg::REG_W-1:0] rd;
	logic [core_pkg::REG_W-1:0] rs;
	logic [core_pkg::REG_W-1:0] rt;
	logic [core_pkg::IMM_W-1:0] imm;
	logic halt;
	logic running;
	core_pkg::slot_t chk_addr; // answer lookup by store slot.
	core_pkg::word_t chk_data;

	load_table #(.entry_t(core_pkg::instr_t)) u_prog_table (
		.clk(clk),
		.wen(prog_wen),
		.waddr(prog_addr),
		.wdata(prog_data),
		.raddr(fetch_addr),
		.rdata(instr)
	);

	load_table #(.entry_t(core_pkg::word_t)) u_ans_table (
		.clk(clk),
		.wen(ans_wen),
		.waddr(ans_addr),
		.wdata(ans_data),
		.raddr(chk_addr),
		.rdata(chk_data)
	);

	instr_decode u_instr_decode (
		.clk(clk),
		.rst(rst),
		.start(start),
		.fetch_addr(fetch_addr),
		.instr(instr),
		.issue(issue),
		.op(op),
		.rd(rd),
		.rs(rs),
		.rt(rt),
		.imm(imm),
		.halt(halt),
		.running(running)
	);

	alu_execute u_alu_execute (
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.op(op),
		.rd(rd),
		.rs(rs),
		.rt(rt),
		.imm(imm),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.mem_data(mem_data)
	);

	store_checker u_store_checker (
		.clk(clk),
		.rst(rst),
		.running(running),
		.halt(halt),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.ans_addr(chk_addr),
		.ans_data(chk_data),
		.error_num(error_num),
		.duration(duration),
		.finish(finish)
	);

endmodule

`default_nettype wire

//--- logic/instr_decode.sv
`default_nettype none

module instr_decode (
	input logic clk,
	input logic rst,
	input logic start,
	output core_pkg::slot_t fetch_addr,
	input core_pkg::instr_t instr,
	output logic issue,
	output core_pkg::op_t op,
	output logic [core_pkg::REG_W-1:0] rd,
	output logic [core_pkg::REG_W-1:0] rs,
	output logic [core_pkg::REG_W-1:0] rt,
	output logic [core_pkg::IMM_W-1:0] imm,
	output logic halt,
	output logic running
);

	core_pkg::slot_t pc;
	logic phase; // 0 fetch, 1 issue.

	assign fetch_addr = pc;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc <= '0;
			phase <= 1'b0;
			running <= 1'b0;
			issue <= 1'b0;
			halt <= 1'b0;
		end else begin
			issue <= 1'b0;
			halt <= 1'b0;
			if (!running) begin
				if (start) begin
					pc <= '0;
					phase <= 1'b0;
					running <= 1'b1;
				end
			end else if (!phase) begin
				issue <= 1'b1; // fields are registered on this edge.
				phase <= 1'b1;
			end else begin
				phase <= 1'b0;
				if (op == core_pkg::OP_HALT) begin
					running <= 1'b0;
					halt <= 1'b1;
				end else begin
					pc <= pc + 1'b1;
				end
			end
		end
	end

	// field decode of the fetched word.
	always_ff @(posedge clk) begin
		if (running && !phase) begin
			op <= core_pkg::op_t'(instr.opcode);
			rd <= instr.rd;
			rs <= instr.rs;
			rt <= instr.imm[core_pkg::REG_W-1:0];
			imm <= instr.imm;
		end
	end

endmodule

`default_nettype wire

//--- logic/load_table.sv
`default_nettype none

module load_table #(
	parameter type entry_t = core_pkg::word_t
) (
	input logic clk,
	input logic wen,
	input core_pkg::slot_t waddr,
	input entry_t wdata,
	input core_pkg::slot_t raddr,
	output entry_t rdata
);

	entry_t mem [core_pkg::PROG_DEPTH];

	always_ff @(posedge clk) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
	end

	assign rdata = mem[raddr]; // read is combinational.

endmodule

`default_nettype wire

//--- logic/store_checker.sv
`default_nettype none

module store_checker (
	input logic clk,
	input logic rst,
	input logic running,
	input logic halt,
	input logic mem_wen,
	input core_pkg::slot_t mem_addr,
	input core_pkg::word_t mem_data,
	output core_pkg::slot_t ans_addr,
	input core_pkg::word_t ans_data,
	output logic [core_pkg::ERR_W-1:0] error_num,
	output logic [core_pkg::DUR_W-1:0] duration,
	output logic finish
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_CHECK,
		S_REPORT
	} state_t;

	state_t state;
	core_pkg::word_t store_val;
	logic miss;

	assign ans_addr = mem_addr;
	assign store_val = core_pkg::swap_bytes(mem_data); // back to readable order.
	assign miss = mem_wen && (mem_addr < core_pkg::CHECK_NUM) && (store_val != ans_data);
	assign finish = (state == S_REPORT);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= S_IDLE;
			error_num <= core_pkg::ERR_IDLE;
			duration <= '0;
		end else begin
			case (state)
				S_IDLE, S_REPORT: begin
					// first running cycle counts too.
					if (running) begin
						state <= S_CHECK;
						error_num <= '0;
						duration <= core_pkg::DUR_W'(1);
					end
				end
				S_CHECK: begin
					if (running) begin
						duration <= duration + 1'b1;
					end
					if (miss && error_num != '1) begin
						error_num <= error_num + 1'b1; // saturates.
					end
					if (halt) begin
						state <= S_REPORT;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- project.f
logic/core_pkg.sv
logic/load_table.sv
logic/instr_decode.sv
logic/alu_execute.sv
logic/store_checker.sv
logic/cpu_check_top.sv
tb/store_checker_properties.sv
tb/tb_cpu_check.sv

//--- tb/store_checker_properties.sv
`default_nettype none

module store_checker_properties (
	input logic clk,
	input logic rst,
	input logic running,
	input logic mem_wen,
	input logic in_check,
	input logic [core_pkg::ERR_W-1:0] error_num,
	input logic finish
);
	timeunit 1ns;
	timeprecision 10ps;

	// finish only drops when a new run has begun.
	assert property (@(posedge clk) disable iff (!rst) $fell(finish) |-> $past(running))
		else $error("finish fell without a new run starting");

	assert property (@(posedge clk) disable iff (!rst) in_check |=> error_num >= $past(error_num))
		else $error("error count went down during a check");

	assert property (@(posedge clk) disable iff (!rst) mem_wen |=> !mem_wen)
		else $error("store strobe held high for two cycles");

endmodule

bind store_checker store_checker_properties u_properties (
	.clk(clk),
	.rst(rst),
	.running(running),
	.mem_wen(mem_wen),
	.in_check(state == S_CHECK),
	.error_num(error_num),
	.finish(finish)
);

`default_nettype wire

//--- tb/tb_cpu_check.sv
`default_nettype none

module tb_cpu_check;
	timeunit 1ns;
	timeprecision 10ps;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_RUNS = 20;
	localparam int MAX_LEN = 32; // instructions per program, halt included.
	localparam int RUN_CYCLES = 2 * core_pkg::PROG_DEPTH + 10;

	logic clk;
	logic rst;
	logic start;
	logic prog_wen;
	core_pkg::slot_t prog_addr;
	core_pkg::instr_t prog_data;
	logic ans_wen;
	core_pkg::slot_t ans_addr;
	core_pkg::word_t ans_data;
	logic mem_wen;
	core_pkg::slot_t mem_addr;
	core_pkg::word_t mem_data;
	logic [7:0] error_num;
	logic [15:0] duration;
	logic finish;

	integer seed = 19;
	int fail_count = 0;
	logic [31:0] regs [8]; // model registers, carried from run to run.
	logic [31:0] answers [core_pkg::CHECK_NUM];
	logic [15:0] prog [core_pkg::PROG_DEPTH];
	logic [5:0] exp_slots [$];
	logic [31:0] exp_data [$]; // memory byte order.
	core_pkg::op_t rr_ops [6] = '{core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND,
		core_pkg::OP_OR, core_pkg::OP_XOR, core_pkg::OP_SLT};

	cpu_check_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
		logic [31:0] r;
		for (int i = 0; i < 4; i++) begin
			r[8*i +: 8] = w[8*(3-i) +: 8];
		end
		return r;
	endfunction

	task automatic report_failure();
		fail_count++;
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at the first failing check");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			report_failure();
		end
	endtask

	// one instruction of the reference model.
	task automatic model_step(input logic [15:0] ins);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic wr;
		a = regs[ins[8:6]];
		b = regs[ins[2:0]]; // rt.
		wr = 1'b1;
		res = '0;
		case (ins[15:12])
			core_pkg::OP_ADDI: res = a + {{26{ins[5]}}, ins[5:0]};
			core_pkg::OP_ADD: res = a + b;
			core_pkg::OP_SUB: res = a - b;
			core_pkg::OP_AND: res = a & b;
			core_pkg::OP_OR: res = a | b;
			core_pkg::OP_XOR: res = a ^ b;
			core_pkg::OP_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: wr = 1'b0;
		endcase
		if (ins[15:12] == core_pkg::OP_STORE) begin
			exp_slots.push_back(ins[5:0]);
			exp_data.push_back(reverse_bytes(a));
		end
		if (wr && ins[11:9] != 3'd0) begin
			regs[ins[11:9]] = res;
		end
	endtask

	// random program, each store to its own slot so a clean table gives no errors.
	task automatic build_program(input int n);
		int k;
		logic [5:0] slot;
		logic [63:0] used;
		used = '0;
		for (int i = 0; i < n - 1; i++) begin
			k = rand_below(12);
			prog[i] = 16'($random(seed));
			if (k < 3) begin
				prog[i][15:12] = core_pkg::OP_ADDI;
			end else if (k < 8) begin
				prog[i][15:12] = rr_ops[rand_below(6)];
			end else if (k < 11) begin
				prog[i][15:12] = core_pkg::OP_STORE;
				slot = (rand_below(2) == 0) ? 6'(rand_below(14)) : 6'(rand_below(64));
				while (used[slot]) begin
					slot = slot + 1'b1;
				end
				used[slot] = 1'b1;
				prog[i][5:0] = slot;
			end else begin
				prog[i][15:12] = 4'(8 + rand_below(7)); // unused codes.
			end
			model_step(prog[i]);
		end
		prog[n-1] = {4'(core_pkg::OP_HALT), 12'($random(seed))};
	endtask

	task automatic run_program(input int r);
		int n;
		int idx;
		int exp_err;
		int pulse_at;
		int cyc;
		logic seen_low;
		logic done;
		n = 2 + rand_below(MAX_LEN - 1);
		build_program(n);
		for (int i = 0; i < exp_slots.size(); i++) begin
			if (exp_slots[i] < core_pkg::CHECK_NUM) begin
				answers[exp_slots[i]] = reverse_bytes(exp_data[i]);
			end
		end
		if (r % 3 == 2) begin
			repeat (1 + rand_below(4)) begin
				idx = rand_below(core_pkg::CHECK_NUM);
				answers[idx] = answers[idx] ^ (32'($random(seed)) | 32'h1);
			end
		end
		exp_err = 0;
		for (int i = 0; i < exp_slots.size(); i++) begin
			if (exp_slots[i] < 14 && reverse_bytes(exp_data[i]) !== answers[exp_slots[i]]) begin
				exp_err++;
			end
		end
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			prog_wen <= 1'b1;
			prog_addr <= 6'(i);
			prog_data <= prog[i];
		end
		for (int i = 0; i < core_pkg::CHECK_NUM; i++) begin
			@(posedge clk);
			prog_wen <= 1'b0;
			ans_wen <= 1'b1;
			ans_addr <= 6'(i);
			ans_data <= answers[i];
		end
		@(posedge clk);
		ans_wen <= 1'b0;
		start <= 1'b1;
		pulse_at = (r % 4 == 3) ? 2 + rand_below(2 * n - 3) : -1; // stray start mid-run.
		cyc = 0;
		seen_low = 1'b0;
		done = 1'b0;
		while (!done) begin
			@(posedge clk);
			start <= (cyc == pulse_at);
			@(negedge clk);
			if (cyc > 0 && !seen_low && !finish) begin
				seen_low = 1'b1;
				check_value("error_num", error_num, 32'd0);
			end
			done = seen_low && finish;
			cyc++;
			assert (cyc < RUN_CYCLES) else begin
				$display("run %0d: finish did not rise in time", r);
				report_failure();
			end
		end
		assert (exp_slots.size() == 0) else begin
			$display("run %0d: %0d expected stores never appeared", r, exp_slots.size());
			report_failure();
		end
		check_value("error_num", error_num, exp_err);
		check_value("duration", duration, 2 * n);
	endtask

	// every store pulse is checked against the model, in program order.
	always @(negedge clk) begin
		if (rst && mem_wen) begin
			assert (exp_slots.size() > 0) else begin
				$display("mem_wen pulsed but no store was expected");
				report_failure();
			end
			check_value("mem_addr", mem_addr, exp_slots.pop_front());
			check_value("mem_data", mem_data, exp_data.pop_front());
		end
	end

	initial begin
		#((NUM_RUNS * RUN_CYCLES + 10) * CLK_PERIOD);
		$display("timeout: the runs did not complete in the expected time");
		report_failure();
	end

	initial begin
		rst = 1'b0;
		start = 1'b0;
		prog_wen = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		ans_wen = 1'b0;
		ans_addr = '0;
		ans_data = '0;
		for (int i = 0; i < 8; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < core_pkg::CHECK_NUM; i++) begin
			answers[i] = 32'($random(seed));
		end
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check_value("finish", finish, 32'd0);
		check_value("mem_wen", mem_wen, 32'd0);
		check_value("error_num", error_num, 32'd255);
		check_value("duration", duration, 32'd0);
		for (int r = 0; r < NUM_RUNS; r++) begin
			run_program(r);
		end
		if (fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			report_failure();
		end
	end

endmodule

`default_nettype wire
